// File: hdl/game_port_consts.svh
`ifndef GAME_PORT_CONSTS_SVH
`define GAME_PORT_CONSTS_SVH

// Divider value on which every running axis count steps down.
`define GP_DIV_LAST 265

// Start count for a stick held left or up.
`define GP_AXIS_MIN 8

// Start count for a stick held right or down.
`define GP_AXIS_MAX 391

// Start count for a centred stick, also the offset added to analog values.
`define GP_AXIS_CENTER 200

// Count held in every axis after reset.
`define GP_AXIS_RESET 197

// Last position of the 24-bit Gravis frame.
`define GP_FRAME_LAST 23

`endif

// File: hdl/game_port_pkg.sv
package game_port_pkg;

	// One-shot count of a single axis.
	typedef logic [8:0] axis_count_t;

	// Prescaler between the clock and the axis decrements.
	typedef logic [8:0] div_count_t;

	// Digital buttons, bit 0 up to bit 13.
	// Right, left, down, up, but1..but4, start, select, R1, L1, R2, L2.
	typedef logic [13:0] pad_buttons_t;

	// Signed X in the low byte and signed Y in the high byte.
	typedef logic [15:0] stick_pos_t;

	// Button mode of the port.
	// 0 two sticks, 1 one stick with four buttons, 2 Gravis, 3 as 0.
	typedef logic [1:0] port_mode_t;

	// Bit position inside the Gravis frame.
	typedef logic [4:0] frame_pos_t;

endpackage

// File: hdl/pad_if.sv
`timescale 1ns/1ps

// Button and stick state of both pads, as handed in by the host.
interface pad_if;

	// Pressed buttons of pad 1 and pad 2.
	game_port_pkg::pad_buttons_t dig_1;
	game_port_pkg::pad_buttons_t dig_2;

	// Analog stick positions of pad 1 and pad 2.
	game_port_pkg::stick_pos_t ana_1;
	game_port_pkg::stick_pos_t ana_2;

	// Top level fills the bundle from its own ports.
	modport source (output dig_1, dig_2, ana_1, ana_2);

	// Axis timers need the sticks and the direction buttons.
	modport axis (input dig_1, dig_2, ana_1, ana_2);

	// Button paths only look at the digital state.
	modport pad (input dig_1, dig_2);

endinterface

// File: hdl/axis_oneshot.sv
`timescale 1ns/1ps

`include "game_port_consts.svh"

module axis_oneshot (
	input  logic       clk,
	input  logic       rst_n,
	pad_if.axis        pads,
	input  logic       write,
	input  logic       address,
	output logic [3:0] axis_active
);

	// Start count for one axis.
	// A nonzero analog value wins over the direction buttons.
	function automatic game_port_pkg::axis_count_t load_count(
		input logic [7:0] raw,
		input logic       neg_btn,
		input logic       pos_btn
	);
		game_port_pkg::axis_count_t ext;
		game_port_pkg::axis_count_t scaled;
		ext = {raw[7], raw};
		// Value times 1.5 around the centre, wraps modulo 512.
		scaled = ext + {ext[8], ext[8:1]} + 9'(`GP_AXIS_CENTER);
		if (raw != 8'd0) begin
			return scaled;
		end else if (neg_btn) begin
			return 9'(`GP_AXIS_MIN);
		end else if (pos_btn) begin
			return 9'(`GP_AXIS_MAX);
		end
		return 9'(`GP_AXIS_CENTER);
	endfunction

	// Axis order is 1X, 1Y, 2X, 2Y.
	logic [7:0] raw [4];
	logic [3:0] neg_btn;
	logic [3:0] pos_btn;

	game_port_pkg::axis_count_t count_q [4];
	game_port_pkg::div_count_t  div_q;

	logic load;
	logic tick;

	// Raw signed stick bytes.
	assign raw[0] = pads.ana_1[7:0];
	assign raw[1] = pads.ana_1[15:8];
	assign raw[2] = pads.ana_2[7:0];
	assign raw[3] = pads.ana_2[15:8];

	// Left for X, up for Y.
	assign neg_btn = {pads.dig_2[3], pads.dig_2[1], pads.dig_1[3], pads.dig_1[1]};

	// Right for X, down for Y.
	assign pos_btn = {pads.dig_2[2], pads.dig_2[0], pads.dig_1[2], pads.dig_1[0]};

	// Port write with the select bit set fires all four one-shots.
	assign load = write & address;

	// Divider wraps here and the counts step down.
	assign tick = (div_q == 9'(`GP_DIV_LAST));

	// Shared rate divider.
	// A load restarts it at 1 so the first step lands 265 cycles later.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_q <= '0;
		end else if (load) begin
			div_q <= 9'd1;
		end else if (tick) begin
			div_q <= '0;
		end else begin
			div_q <= div_q + 9'd1;
		end
	end

	// One countdown per axis.
	for (genvar i = 0; i < 4; i++) begin : g_axis
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				count_q[i] <= 9'(`GP_AXIS_RESET);
			end else if (load) begin
				// Load beats a decrement in the same cycle.
				count_q[i] <= load_count(raw[i], neg_btn[i], pos_btn[i]);
			end else if (tick && count_q[i] != '0) begin
				count_q[i] <= count_q[i] - 9'd1;
			end
		end

		// Port bit stays high while the one-shot runs.
		assign axis_active[i] = (count_q[i] != '0);
	end

endmodule

// File: hdl/gravis_serializer.sv
`timescale 1ns/1ps

`include "game_port_consts.svh"

module gravis_serializer (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       clk_grav,
	pad_if.pad         pads,
	output logic       grav_clk_q,
	output logic [1:0] grav_data
);

	game_port_pkg::frame_pos_t pos_q;

	logic       grav_rise;
	logic [1:0] frame_bit;

	// Slow strobe low last cycle and high now.
	assign grav_rise = ~grav_clk_q & clk_grav;

	// Frame table, player 2 in bit 1 and player 1 in bit 0.
	// Header is a 0 then five 1s, each button group starts with a 0.
	always_comb begin
		case (pos_q)
			5'd1, 5'd2, 5'd3, 5'd4, 5'd5: frame_bit = 2'b11;
			// Select, start, R2, but4.
			5'd7:  frame_bit = {pads.dig_2[9], pads.dig_1[9]};
			5'd8:  frame_bit = {pads.dig_2[8], pads.dig_1[8]};
			5'd9:  frame_bit = {pads.dig_2[12], pads.dig_1[12]};
			5'd10: frame_bit = {pads.dig_2[7], pads.dig_1[7]};
			// L2, but2, but1, but3.
			5'd12: frame_bit = {pads.dig_2[13], pads.dig_1[13]};
			5'd13: frame_bit = {pads.dig_2[5], pads.dig_1[5]};
			5'd14: frame_bit = {pads.dig_2[4], pads.dig_1[4]};
			5'd15: frame_bit = {pads.dig_2[6], pads.dig_1[6]};
			// L1, R1, up, down.
			5'd17: frame_bit = {pads.dig_2[11], pads.dig_1[11]};
			5'd18: frame_bit = {pads.dig_2[10], pads.dig_1[10]};
			5'd19: frame_bit = {pads.dig_2[3], pads.dig_1[3]};
			5'd20: frame_bit = {pads.dig_2[2], pads.dig_1[2]};
			// Right, left.
			5'd22: frame_bit = {pads.dig_2[0], pads.dig_1[0]};
			5'd23: frame_bit = {pads.dig_2[1], pads.dig_1[1]};
			// Separators at 0, 6, 11, 16 and 21.
			default: frame_bit = 2'b00;
		endcase
	end

	// Sampled strobe, it also drives the clock lines of the port.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grav_clk_q <= 1'b0;
		end else begin
			grav_clk_q <= clk_grav;
		end
	end

	// One frame bit per strobe rise.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos_q     <= '0;
			grav_data <= 2'b00;
		end else if (grav_rise) begin
			grav_data <= frame_bit;
			// Wrap back to the header after the last bit.
			if (pos_q == 5'(`GP_FRAME_LAST)) begin
				pos_q <= '0;
			end else begin
				pos_q <= pos_q + 5'd1;
			end
		end
	end

endmodule

// File: hdl/button_lines.sv
`timescale 1ns/1ps

module button_lines (
	input  logic                     clk,
	input  logic                     rst_n,
	input  game_port_pkg::port_mode_t mode,
	pad_if.pad                       pads,
	input  logic                     grav_clk_q,
	input  logic [1:0]               grav_data,
	output logic [3:0]               buttons
);

	// Next value of jb4..jb1.
	logic [3:0] lines_d;

	// Port lines are active low, pressed buttons pull them to 0.
	always_comb begin
		case (mode)
			2'd2: begin
				// Clock on jb1 and jb3, data on jb2 and jb4.
				lines_d = {grav_data[1], grav_clk_q, grav_data[0], grav_clk_q};
			end
			2'd1: begin
				// All four buttons of pad 1.
				lines_d = ~pads.dig_1[7:4];
			end
			default: begin
				// but1 and but2 of each pad, mode 3 lands here too.
				lines_d = ~{pads.dig_2[5:4], pads.dig_1[5:4]};
			end
		endcase
	end

	// Lines idle high.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buttons <= 4'b1111;
		end else begin
			buttons <= lines_d;
		end
	end

endmodule

// File: hdl/game_port.sv
`timescale 1ns/1ps

module game_port (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       clk_grav,
	input  game_port_pkg::pad_buttons_t dig_1,
	input  game_port_pkg::pad_buttons_t dig_2,
	input  game_port_pkg::stick_pos_t   ana_1,
	input  game_port_pkg::stick_pos_t   ana_2,
	input  game_port_pkg::port_mode_t   mode,
	input  logic                       address,
	input  logic                       write,
	output logic [7:0]                 readdata
);

	// Pad state shared by the three blocks.
	pad_if pads_if ();

	// Strobe and serial data from the Gravis block.
	logic       grav_clk_q;
	logic [1:0] grav_data;

	// jb4..jb1 and the four one-shot bits.
	logic [3:0] buttons;
	logic [3:0] axis_active;

	assign pads_if.dig_1 = dig_1;
	assign pads_if.dig_2 = dig_2;
	assign pads_if.ana_1 = ana_1;
	assign pads_if.ana_2 = ana_2;

	// Four one-shots fired by a port write.
	axis_oneshot axis_oneshot_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.pads        (pads_if),
		.write       (write),
		.address     (address),
		.axis_active (axis_active)
	);

	// Serial frame for the Gravis mode.
	gravis_serializer gravis_serializer_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.clk_grav   (clk_grav),
		.pads       (pads_if),
		.grav_clk_q (grav_clk_q),
		.grav_data  (grav_data)
	);

	// Mode dependent button lines.
	button_lines button_lines_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.mode       (mode),
		.pads       (pads_if),
		.grav_clk_q (grav_clk_q),
		.grav_data  (grav_data),
		.buttons    (buttons)
	);

	// Buttons on top, then 2Y, 2X, 1Y, 1X.
	// Straight from registers, so reads see no extra delay.
	assign readdata = {buttons, axis_active};

endmodule

// File: bench/game_port_sva.sv
`timescale 1ns/1ps

module game_port_sva (
	input logic                      clk,
	input logic                      rst_n,
	input logic                      write,
	input logic                      address,
	input game_port_pkg::port_mode_t mode,
	input logic [7:0]                readdata
);

	// A load starts all four one-shots at once.
	assert property (@(posedge clk) disable iff (!rst_n)
		(write && address) |=> (readdata[3:0] == 4'hF))
		else $error("axis bits not all high after a load");

	// An expired axis only comes back through a new load.
	for (genvar i = 0; i < 4; i++) begin : g_hold_low
		assert property (@(posedge clk) disable iff (!rst_n)
			(!readdata[i] && !(write && address)) |=> !readdata[i])
			else $error("axis bit %0d rose without a load", i);
	end

	// Both Gravis clock lines carry the same sampled strobe.
	// Lines are registered, so the mode of the previous cycle decides.
	assert property (@(posedge clk) disable iff (!rst_n)
		(mode == 2'd2) |=> (readdata[4] == readdata[6]))
		else $error("Gravis clock lines differ");

	// Every register bit is known once out of reset.
	assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(readdata))
		else $error("readdata holds an unknown bit");

endmodule

bind game_port game_port_sva game_port_sva_i (
	.clk      (clk),
	.rst_n    (rst_n),
	.write    (write),
	.address  (address),
	.mode     (mode),
	.readdata (readdata)
);

// File: bench/game_port_tb.sv
`timescale 1ns/1ps

`include "game_port_consts.svh"

module game_port_tb;

	// About six full 391-count drops plus the Gravis frames.
	localparam int TIMEOUT_CYCLES = 600000;

	logic                        clk = 1'b0;
	logic                        rst_n;
	logic                        clk_grav;
	game_port_pkg::pad_buttons_t dig_1;
	game_port_pkg::pad_buttons_t dig_2;
	game_port_pkg::stick_pos_t   ana_1;
	game_port_pkg::stick_pos_t   ana_2;
	game_port_pkg::port_mode_t   mode;
	logic                        address;
	logic                        write;
	logic [7:0]                  readdata;

	int                          cycle_count = 0;
	logic [31:0]                 rand_state = 32'h54fb;
	// Per axis, 1X, 1Y, 2X, 2Y.
	int                          drop_at [4];
	game_port_pkg::axis_count_t  exp_count [4];

	game_port game_port_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.clk_grav (clk_grav),
		.dig_1    (dig_1),
		.dig_2    (dig_2),
		.ana_1    (ana_1),
		.ana_2    (ana_2),
		.mode     (mode),
		.address  (address),
		.write    (write),
		.readdata (readdata)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			fail_run("simulation timed out");
		end
	end

	task automatic fail_run(input string msg);
		$display("Checks failed");
		$fatal(1, "%s", msg);
	endtask

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	task automatic check_count(input string name, input game_port_pkg::axis_count_t expected,
		input game_port_pkg::axis_count_t actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
			fail_run($sformatf("%s: axis count mismatch", name));
		end
	endtask

	task automatic check_bits(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			fail_run($sformatf("%s: readdata mismatch", name));
		end
	endtask

	// Start count of one axis from the stick byte and its two directions.
	function automatic game_port_pkg::axis_count_t expected_count(input logic [7:0] raw,
		input logic neg_btn, input logic pos_btn);
		int r;
		int v;
		r = int'($signed(raw));
		if (r != 0) begin
			v = r + (r >>> 1) + `GP_AXIS_CENTER;
			v = ((v % 512) + 512) % 512;
			return game_port_pkg::axis_count_t'(v);
		end
		if (neg_btn) begin
			return game_port_pkg::axis_count_t'(`GP_AXIS_MIN);
		end
		if (pos_btn) begin
			return game_port_pkg::axis_count_t'(`GP_AXIS_MAX);
		end
		return game_port_pkg::axis_count_t'(`GP_AXIS_CENTER);
	endfunction

	// Left and right for X, up and down for Y.
	task automatic set_expected();
		exp_count[0] = expected_count(ana_1[7:0], dig_1[1], dig_1[0]);
		exp_count[1] = expected_count(ana_1[15:8], dig_1[3], dig_1[2]);
		exp_count[2] = expected_count(ana_2[7:0], dig_2[1], dig_2[0]);
		exp_count[3] = expected_count(ana_2[15:8], dig_2[3], dig_2[2]);
	endtask

	// Gravis frame bit of one player at a frame position.
	function automatic logic frame_bit_for(input int pos, input game_port_pkg::pad_buttons_t d);
		case (pos)
			1, 2, 3, 4, 5: return 1'b1;
			7:  return d[9];
			8:  return d[8];
			9:  return d[12];
			10: return d[7];
			12: return d[13];
			13: return d[5];
			14: return d[4];
			15: return d[6];
			17: return d[11];
			18: return d[10];
			19: return d[3];
			20: return d[2];
			22: return d[0];
			23: return d[1];
			default: return 1'b0;
		endcase
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// One-cycle port write, entered and left on a falling edge.
	task automatic pulse_write(input logic addr);
		write   = 1'b1;
		address = addr;
		@(posedge clk);
		@(negedge clk);
		write   = 1'b0;
		address = 1'b0;
	endtask

	// Cycles from the load edge to the fall of each axis bit.
	task automatic measure_drops(input string name);
		int         m;
		logic [3:0] seen;
		m    = 0;
		seen = 4'h0;
		check_bits({name, " start"}, 8'h0F, {4'h0, readdata[3:0]});
		while (seen != 4'hF) begin
			for (int i = 0; i < 4; i++) begin
				if (!seen[i] && !readdata[i]) begin
					drop_at[i] = m;
					seen[i]    = 1'b1;
				end
			end
			@(negedge clk);
			m++;
		end
	endtask

	// A count N drops at 265 + 266*(N-1), turned back into N here.
	task automatic check_drops(input string name);
		int                         m;
		game_port_pkg::axis_count_t n;
		for (int i = 0; i < 4; i++) begin
			m = drop_at[i];
			if (m < `GP_DIV_LAST || (m - `GP_DIV_LAST) % (`GP_DIV_LAST + 1) != 0) begin
				fail_run($sformatf("%s: axis %0d fell at cycle %0d, between decrement steps",
					name, i, m));
			end
			n = game_port_pkg::axis_count_t'((m - `GP_DIV_LAST) / (`GP_DIV_LAST + 1) + 1);
			check_count($sformatf("%s axis %0d", name, i), exp_count[i], n);
		end
	endtask

	task automatic reset_values();
		check_bits("reset", 8'hFF, readdata);
		@(negedge clk);
		check_bits("reset hold", 8'hFF, readdata);
	endtask

	task automatic button_modes();
		game_port_pkg::port_mode_t modes [3];
		logic [3:0]                jb;
		modes = '{2'd0, 2'd1, 2'd3};
		for (int k = 0; k < 3; k++) begin
			mode = modes[k];
			repeat (6) begin
				dig_1 = game_port_pkg::pad_buttons_t'(next_rand() >> 8);
				dig_2 = game_port_pkg::pad_buttons_t'(next_rand() >> 8);
				@(posedge clk);
				@(posedge clk);
				@(negedge clk);
				// jb4..jb3..jb2..jb1, pressed pulls the line low.
				if (mode == 2'd1) begin
					jb = {~dig_1[7], ~dig_1[6], ~dig_1[5], ~dig_1[4]};
				end else begin
					jb = {~dig_2[5], ~dig_2[4], ~dig_1[5], ~dig_1[4]};
				end
				check_bits($sformatf("mode %0d buttons", mode), {jb, 4'h0},
					{readdata[7:4], 4'h0});
			end
		end
		mode = 2'd0;
	endtask

	task automatic gravis_frames();
		logic p1;
		logic p2;
		mode = 2'd2;
		for (int k = 0; k < 48; k++) begin
			if (k % 24 == 0) begin
				dig_1 = game_port_pkg::pad_buttons_t'(next_rand() >> 8);
				dig_2 = game_port_pkg::pad_buttons_t'(next_rand() >> 8);
			end
			p1       = frame_bit_for(k % 24, dig_1);
			p2       = frame_bit_for(k % 24, dig_2);
			clk_grav = 1'b1;
			@(posedge clk);
			@(posedge clk);
			@(negedge clk);
			check_bits($sformatf("gravis rise %0d", k), {p2, 1'b1, p1, 1'b1, 4'h0},
				{readdata[7:4], 4'h0});
			idle_cycles(6);
			clk_grav = 1'b0;
			@(posedge clk);
			@(posedge clk);
			@(negedge clk);
			// Data holds while the strobe is low.
			check_bits($sformatf("gravis fall %0d", k), {p2, 1'b0, p1, 1'b0, 4'h0},
				{readdata[7:4], 4'h0});
			idle_cycles(6);
		end
		mode = 2'd0;
	endtask

	task automatic digital_axes();
		ana_1 = '0;
		ana_2 = '0;
		// Pad 1 left and down, pad 2 right with but1 that must not matter.
		dig_1 = 14'h0006;
		dig_2 = 14'h0011;
		exp_count[0] = `GP_AXIS_MIN;
		exp_count[1] = `GP_AXIS_MAX;
		exp_count[2] = `GP_AXIS_MAX;
		exp_count[3] = `GP_AXIS_CENTER;
		pulse_write(1'b1);
		measure_drops("digital");
		check_drops("digital");
		// Select bit clear fires nothing.
		pulse_write(1'b0);
		idle_cycles(300);
		check_bits("address 0 write", 8'h00, {4'h0, readdata[3:0]});
	endtask

	task automatic analog_axes();
		ana_1 = game_port_pkg::stick_pos_t'(next_rand() >> 8);
		ana_2 = game_port_pkg::stick_pos_t'(next_rand() >> 8);
		dig_1 = game_port_pkg::pad_buttons_t'(next_rand() >> 8);
		dig_2 = game_port_pkg::pad_buttons_t'(next_rand() >> 8);
		set_expected();
		pulse_write(1'b1);
		measure_drops("analog random");
		check_drops("analog random");
		// Extremes, with directions pressed against each stick.
		ana_1 = {8'h7F, 8'h80};
		ana_2 = {8'h80, 8'h7F};
		dig_1 = 14'h0009;
		dig_2 = 14'h0006;
		exp_count[0] = 9'd8;
		exp_count[1] = 9'd390;
		exp_count[2] = 9'd390;
		exp_count[3] = 9'd8;
		pulse_write(1'b1);
		measure_drops("analog extremes");
		check_drops("analog extremes");
	endtask

	task automatic axis_reload();
		// Pad 1 at -128 on both axes expires early.
		ana_1 = 16'h8080;
		ana_2 = game_port_pkg::stick_pos_t'(next_rand() >> 8);
		pulse_write(1'b1);
		idle_cycles(2500);
		check_bits("reload early drop", 8'h00, {6'h0, readdata[1:0]});
		ana_1 = game_port_pkg::stick_pos_t'(next_rand() >> 8);
		ana_2 = game_port_pkg::stick_pos_t'(next_rand() >> 8);
		dig_1 = game_port_pkg::pad_buttons_t'(next_rand() >> 8);
		dig_2 = game_port_pkg::pad_buttons_t'(next_rand() >> 8);
		set_expected();
		pulse_write(1'b1);
		measure_drops("reload");
		check_drops("reload");
	endtask

	initial begin
		rst_n    = 1'b0;
		clk_grav = 1'b0;
		dig_1    = '0;
		dig_2    = '0;
		ana_1    = '0;
		ana_2    = '0;
		mode     = 2'd0;
		address  = 1'b0;
		write    = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		reset_values();
		button_modes();
		gravis_frames();
		digital_axes();
		analog_axes();
		axis_reload();
		$display("All checks passed");
		$finish;
	end

endmodule

// File: sources.f
+incdir+hdl
hdl/game_port_pkg.sv
hdl/pad_if.sv
hdl/axis_oneshot.sv
hdl/gravis_serializer.sv
hdl/button_lines.sv
hdl/game_port.sv
bench/game_port_sva.sv
bench/game_port_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the game port testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f sources.f \
	--top-module game_port_tb \
	-o game_port_sim

./obj_dir/game_port_sim
